// File: build.f
src/gl_pkg.sv
src/gl_mat_if.sv
src/gl_decode.sv
src/gl_matrix_stack.sv
src/gl_mat_vec_mul.sv
src/gl_vertex_fifo.sv
src/gl_geometry.sv
dv/gl_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = gl_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/gl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module gl_tb
    import gl_pkg::*;
();
    localparam int NUM_TESTS  = 6;
    localparam int SLOW_TEST  = 6;      // Sink held back here so the FIFO fills
    localparam int SLOW_EXTRA = 80;
    localparam int STALL_MIN  = 20;     // Ack wait that only a full FIFO explains
    localparam int HOST_LIMIT = 500;
    localparam int SINK_LIMIT = 1000;

    logic              clk;
    logic              rst_n;
    logic              cmd_req;
    logic [WORD_W-1:0] cmd_word;
    logic              cmd_ack;
    logic              out_req;
    logic [WORD_W-1:0] out_x;
    logic [WORD_W-1:0] out_y;
    logic [WORD_W-1:0] out_z;
    logic [WORD_W-1:0] out_w;
    logic [WORD_W-1:0] out_r;
    logic [WORD_W-1:0] out_g;
    logic [WORD_W-1:0] out_b;
    logic              out_ack;

    int                  stim_test [$];     // Stimulus table
    logic [WORD_W-1:0]   stim_word [$];
    int                  exp_test  [$];     // Expected vertex records
    logic [VEC_W-1:0]    exp_pos   [$];
    logic [3*WORD_W-1:0] exp_color [$];
    int                  test_errs [1:NUM_TESTS];
    int                  test_recs [1:NUM_TESTS];
    int                  max_wait  [1:NUM_TESTS];
    int                  seed = 32'hc83d;
    logic                timed_out;

    gl_geometry i_gl_geometry (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd_word (cmd_word),
        .cmd_ack  (cmd_ack),
        .out_req  (out_req),
        .out_x    (out_x),
        .out_y    (out_y),
        .out_z    (out_z),
        .out_w    (out_w),
        .out_r    (out_r),
        .out_g    (out_g),
        .out_b    (out_b),
        .out_ack  (out_ack)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Q16.16 value of num/den for a power-of-two den
    function automatic logic [WORD_W-1:0] qfix(input int num, input int den);
        return WORD_W'((num * (1 << FRAC_W)) / den);
    endfunction

    //////////////////////////////
    // Table building
    task automatic add_word(input int t, input logic [WORD_W-1:0] w);
        stim_test.push_back(t);
        stim_word.push_back(w);
    endtask

    task automatic add_cmd(input int t, input logic [7:0] op, input logic [23:0] imm);
        add_word(t, {op, imm});
    endtask

    task automatic add_vertex(input int t, input logic [WORD_W-1:0] x,
                              input logic [WORD_W-1:0] y, input logic [WORD_W-1:0] z);
        add_cmd(t, OP_VERTEX, 24'h0);
        add_word(t, x);
        add_word(t, y);
        add_word(t, z);
    endtask

    // Scale on the diagonal and translation in column 3 in column-major order
    task automatic add_matrix(input int t, input logic [7:0] op,
                              input logic [WORD_W-1:0] sx, input logic [WORD_W-1:0] sy,
                              input logic [WORD_W-1:0] sz, input logic [WORD_W-1:0] tx,
                              input logic [WORD_W-1:0] ty, input logic [WORD_W-1:0] tz);
        logic [WORD_W-1:0] diag  [4];
        logic [WORD_W-1:0] trans [4];
        diag  = '{sx, sy, sz, ONE_Q};
        trans = '{tx, ty, tz, 32'h0};
        add_cmd(t, op, 24'h0);
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
            begin
                if (c == r)
                    add_word(t, diag[r]);
                else if (c == 3)
                    add_word(t, trans[r]);
                else
                    add_word(t, 32'h0);
            end
    endtask

    task automatic add_expect(input int t, input int x, input int y, input int z,
                              input logic [3*WORD_W-1:0] rgb);
        exp_test.push_back(t);
        exp_pos.push_back({ONE_Q, qfix(z, 1), qfix(y, 1), qfix(x, 1)});
        exp_color.push_back(rgb);
    endtask

    task automatic build_tables();
        logic [3*WORD_W-1:0] rgb;
        rgb = {qfix(1, 1), qfix(1, 4), qfix(1, 2)};  // b g r
        // Test 1 with reset state and color
        add_vertex(1, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(1, 1, 2, 3, '0);
        add_cmd(1, OP_COLOR, 24'h0);
        add_word(1, qfix(1, 2));
        add_word(1, qfix(1, 4));
        add_word(1, qfix(1, 1));
        add_vertex(1, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(1, 1, 2, 3, rgb);
        // Test 2 with a modelview translation
        add_matrix(2, OP_LOADMATRIX, ONE_Q, ONE_Q, ONE_Q, qfix(10, 1), qfix(20, 1), qfix(30, 1));
        add_vertex(2, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(2, 11, 22, 33, rgb);
        // Test 3 with a projection scale after the translation
        add_cmd(3, OP_MATRIXMODE, 24'h1);
        add_matrix(3, OP_LOADMATRIX, qfix(2, 1), qfix(1, 2), qfix(3, 1), 32'h0, 32'h0, 32'h0);
        add_vertex(3, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(3, 22, 11, 99, rgb);
        add_cmd(3, OP_LOADID, 24'h0);                 // Projection back to identity
        // Test 4 with push, identity and pop
        add_cmd(4, OP_MATRIXMODE, 24'h0);
        add_cmd(4, OP_PUSHMATRIX, 24'h0);
        add_cmd(4, OP_LOADID, 24'h0);
        add_vertex(4, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(4, 1, 2, 3, rgb);
        add_cmd(4, OP_POPMATRIX, 24'h0);
        add_vertex(4, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(4, 11, 22, 33, rgb);
        // Test 5 with translation times scale
        add_matrix(5, OP_MULTMATRIX, qfix(2, 1), qfix(3, 1), qfix(4, 1), 32'h0, 32'h0, 32'h0);
        add_vertex(5, qfix(1, 1), qfix(2, 1), qfix(3, 1));
        add_expect(5, 12, 26, 42, rgb);
        add_vertex(5, qfix(-1, 1), qfix(1, 2), 32'h0);
        exp_test.push_back(5);                        // y lands on 21.5
        exp_pos.push_back({ONE_Q, qfix(30, 1), qfix(43, 2), qfix(8, 1)});
        exp_color.push_back(rgb);
        // Test 6 as a burst
        for (int i = 0; i < 8; i++)
        begin
            add_vertex(6, qfix(i, 1), qfix(-i, 1), qfix(i, 2));
            add_expect(6, 2 * i + 10, 20 - 3 * i, 2 * i + 30, rgb);
        end
    endtask

    //////////////////////////////
    // Checks
    task automatic check_pos(input int t, input logic [VEC_W-1:0] got,
                             input logic [VEC_W-1:0] expected);
        string names [4];
        names = '{"out_x", "out_y", "out_z", "out_w"};
        for (int i = 0; i < 4; i++)
            if (got[i*WORD_W +: WORD_W] !== expected[i*WORD_W +: WORD_W])
            begin
                $display("** Error: test %0d %s = %h, expected %h", t, names[i],
                         got[i*WORD_W +: WORD_W], expected[i*WORD_W +: WORD_W]);
                test_errs[t]++;
            end
    endtask

    task automatic check_color(input int t, input logic [3*WORD_W-1:0] got,
                               input logic [3*WORD_W-1:0] expected);
        string names [3];
        names = '{"out_r", "out_g", "out_b"};
        for (int i = 0; i < 3; i++)
            if (got[i*WORD_W +: WORD_W] !== expected[i*WORD_W +: WORD_W])
            begin
                $display("** Error: test %0d %s = %h, expected %h", t, names[i],
                         got[i*WORD_W +: WORD_W], expected[i*WORD_W +: WORD_W]);
                test_errs[t]++;
            end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
    endtask

    task automatic report_test(input int t);
        if (t == SLOW_TEST && max_wait[t] < STALL_MIN)
        begin
            $display("Test %0d: cmd_ack was never held off by a full FIFO", t);
            test_errs[t]++;
        end
        $display("Test %0d: %s, %0d vertices, %0d errors", t,
                 (test_errs[t] == 0) ? "pass" : "fail", test_recs[t], test_errs[t]);
    endtask

    //////////////////////////////
    // Host and sink
    task automatic send_word(input int t, input logic [WORD_W-1:0] w);
        int n;
        n = 0;
        @(posedge clk);
        cmd_word <= w;
        cmd_req  <= 1'b1;
        @(posedge clk);
        while (!cmd_ack && !timed_out)
        begin
            if (n == HOST_LIMIT)
                note_timeout("cmd_ack never rose for a command word");
            else
            begin
                n++;
                @(posedge clk);
            end
        end
        if (n > max_wait[t])
            max_wait[t] = n;
        cmd_req <= 1'b0;
        n = 0;
        @(posedge clk);
        while (cmd_ack && !timed_out)
        begin
            if (n == HOST_LIMIT)
                note_timeout("cmd_ack stayed high after cmd_req dropped");
            else
            begin
                n++;
                @(posedge clk);
            end
        end
    endtask

    task automatic run_sink();
        int          n;
        int          t;
        int          delay;
        logic [31:0] rnd;
        for (int k = 0; k < exp_test.size() && !timed_out; k++)
        begin
            t = exp_test[k];
            n = 0;
            @(posedge clk);
            while (!out_req && !timed_out)
            begin
                if (n == SINK_LIMIT)
                    note_timeout("no vertex was offered on out_req");
                else
                begin
                    n++;
                    @(posedge clk);
                end
            end
            if (!timed_out)
            begin
                check_pos(t, {out_w, out_z, out_y, out_x}, exp_pos[k]);
                check_color(t, {out_b, out_g, out_r}, exp_color[k]);
                test_recs[t]++;
                rnd   = $random(seed);
                delay = int'(rnd[2:0]);
                if (t == SLOW_TEST)
                    delay += SLOW_EXTRA;
                repeat (delay) @(posedge clk);
                out_ack <= 1'b1;
                n = 0;
                @(posedge clk);
                while (out_req && !timed_out)
                begin
                    if (n == SINK_LIMIT)
                        note_timeout("out_req stayed high after out_ack");
                    else
                    begin
                        n++;
                        @(posedge clk);
                    end
                end
                out_ack <= 1'b0;
                if (k + 1 == exp_test.size() || exp_test[k + 1] != t)
                    report_test(t);
            end
        end
    endtask

    initial
    begin
        int passed;
        int failed;
        int extra;
        int total;
        passed    = 0;
        failed    = 0;
        extra     = 0;
        total     = 0;
        timed_out = 1'b0;
        rst_n    <= 1'b0;
        cmd_req  <= 1'b0;
        cmd_word <= '0;
        out_ack  <= 1'b0;
        build_tables();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fork
            for (int k = 0; k < stim_word.size() && !timed_out; k++)
                send_word(stim_test[k], stim_word[k]);
            run_sink();
        join
        repeat (50) @(posedge clk);
        if (out_req)                                  // Duplicate or stray entry
        begin
            $display("An extra vertex was offered after the last expected one");
            extra++;
        end
        for (int t = 1; t <= NUM_TESTS; t++)
        begin
            total += test_recs[t];
            if (test_errs[t] == 0)
                passed++;
            else
                failed++;
        end
        $display("Summary: %0d tests passed, %0d failed, %0d vertices checked",
                 passed, failed, total);
        if (failed == 0 && extra == 0 && !timed_out)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/gl_geometry.sv
`timescale 1ns/100ps
`default_nettype none

module gl_geometry
    import gl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_req,
    input  logic [WORD_W-1:0] cmd_word,
    output logic              cmd_ack,
    output logic              out_req,
    output logic [WORD_W-1:0] out_x,
    output logic [WORD_W-1:0] out_y,
    output logic [WORD_W-1:0] out_z,
    output logic [WORD_W-1:0] out_w,
    output logic [WORD_W-1:0] out_r,
    output logic [WORD_W-1:0] out_g,
    output logic [WORD_W-1:0] out_b,
    input  logic              out_ack
);
    logic             mul_start;
    logic             mul_done;
    logic [VEC_W-1:0] mul_vec;
    logic [VEC_W-1:0] mul_result;
    logic             fifo_push;
    logic             fifo_full;
    logic [OUT_W-1:0] fifo_data;
    logic [OUT_W-1:0] out_data;

    gl_mat_if mat_bus ();

    gl_decode i_gl_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd_word   (cmd_word),
        .cmd_ack    (cmd_ack),
        .mat        (mat_bus.ctrl),
        .mul_start  (mul_start),
        .mul_vec    (mul_vec),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .fifo_push  (fifo_push),
        .fifo_data  (fifo_data),
        .fifo_full  (fifo_full)
    );

    gl_matrix_stack i_gl_matrix_stack (
        .clk   (clk),
        .rst_n (rst_n),
        .mat   (mat_bus.store)
    );

    // Matrix operand is the current matrix of the addressed mode
    gl_mat_vec_mul i_gl_mat_vec_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (mul_start),
        .mat    (mat_bus.mat),
        .vec    (mul_vec),
        .done   (mul_done),
        .result (mul_result)
    );

    gl_vertex_fifo i_gl_vertex_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_data (fifo_data),
        .full      (fifo_full),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_ack   (out_ack)
    );

    //////////////////////////////
    // FIFO entry split
    assign out_x = out_data[0*WORD_W +: WORD_W];
    assign out_y = out_data[1*WORD_W +: WORD_W];
    assign out_z = out_data[2*WORD_W +: WORD_W];
    assign out_w = out_data[3*WORD_W +: WORD_W];
    assign out_r = out_data[4*WORD_W +: WORD_W];    // Color rides above position
    assign out_g = out_data[5*WORD_W +: WORD_W];
    assign out_b = out_data[6*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// File: src/gl_vertex_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module gl_vertex_fifo
    import gl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [OUT_W-1:0] push_data,
    output logic             full,
    output logic             out_req,
    output logic [OUT_W-1:0] out_data,
    input  logic             out_ack
);
    logic [OUT_W-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  ack_wait;    // Entry taken, sink still holds ack
    logic                  pop;

    assign full     = count == (FIFO_PTR_W+1)'(FIFO_DEPTH);
    assign pop      = out_req && out_ack;
    assign out_data = mem[rd_ptr];      // Head entry

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            out_req  <= 1'b0;
            ack_wait <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase

            //////////////////////////////
            // Output handshake
            if (pop)
            begin
                out_req  <= 1'b0;
                ack_wait <= 1'b1;
            end
            else if (ack_wait)
                ack_wait <= out_ack;            // Clears once ack is seen low
            else if (!out_req && count != '0)
                out_req <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/gl_mat_vec_mul.sv
`timescale 1ns/100ps
`default_nettype none

module gl_mat_vec_mul
    import gl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [MAT_W-1:0] mat,
    input  logic [VEC_W-1:0] vec,
    output logic             done,
    output logic [VEC_W-1:0] result
);
    logic [VEC_W-1:0]  vec_q;
    logic [1:0]        row_q;
    logic              busy;
    logic [VEC_W-1:0]  v;
    logic [1:0]        row;
    logic [WORD_W-1:0] dot;

    // Q16.16 product, 64 bits wide, shifted back and truncated
    function automatic logic [WORD_W-1:0] qmul(input logic signed [WORD_W-1:0] a,
                                               input logic signed [WORD_W-1:0] b);
        logic signed [2*WORD_W-1:0] p;
        p = a * b;
        return WORD_W'(p >>> FRAC_W);
    endfunction

    // Row 0 is done in the start cycle, straight from the input
    assign v   = start ? vec : vec_q;
    assign row = start ? 2'd0 : row_q;

    always_comb
    begin
        dot = '0;
        for (int c = 0; c < 4; c++)
            dot = dot + qmul(mat[(c*4 + row)*WORD_W +: WORD_W], v[c*WORD_W +: WORD_W]);
    end

    //////////////////////////////
    // Row sequencing
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy  <= 1'b0;
            row_q <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= busy && row_q == 2'd3;      // Row 3 lands with done
            if (start)
            begin
                busy  <= 1'b1;
                row_q <= 2'd1;
            end
            else if (busy)
            begin
                row_q <= row_q + 1'b1;
                if (row_q == 2'd3)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            vec_q <= vec;
        if (start || busy)
            result[row*WORD_W +: WORD_W] <= dot;
    end

endmodule

`default_nettype wire

// File: src/gl_matrix_stack.sv
`timescale 1ns/100ps
`default_nettype none

module gl_matrix_stack
    import gl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    gl_mat_if.store mat
);
    logic [MAT_W-1:0] cur  [2];                 // Indexed by mode
    logic [MAT_W-1:0] save [2][STACK_DEPTH];
    logic [SP_W-1:0]  sp   [2];
    logic [MAT_W-1:0] staging;
    logic [SP_W-1:0]  sp_dec;
    logic             do_push;
    logic             do_pop;

    function automatic logic [MAT_W-1:0] identity_mat();
        logic [MAT_W-1:0] id;
        id = '0;
        for (int i = 0; i < 4; i++)
            id[i*5*WORD_W +: WORD_W] = ONE_Q;   // Diagonal at 0, 5, 10, 15
        return id;
    endfunction

    // Full push and empty pop are dropped
    assign do_push = mat.push && sp[mat.mode] != SP_W'(STACK_DEPTH);
    assign do_pop  = mat.pop && sp[mat.mode] != '0;
    assign sp_dec  = sp[mat.mode] - 1'b1;

    assign mat.mat = cur[mat.mode];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int m = 0; m < 2; m++)
            begin
                cur[m] <= identity_mat();
                sp[m]  <= '0;
            end
        end
        else if (mat.commit)
            cur[mat.mode] <= staging;
        else if (mat.identity)
            cur[mat.mode] <= identity_mat();
        else if (do_push)
            sp[mat.mode] <= sp[mat.mode] + 1'b1;
        else if (do_pop)
        begin
            cur[mat.mode] <= save[mat.mode][sp_dec[SP_W-2:0]];
            sp[mat.mode]  <= sp_dec;
        end
    end

    //////////////////////////////
    // Save area and staging
    always_ff @(posedge clk)
    begin
        if (do_push && !mat.commit && !mat.identity)
            save[mat.mode][sp[mat.mode][SP_W-2:0]] <= cur[mat.mode];
        if (mat.load_en)
            staging[mat.load_idx*WORD_W +: WORD_W] <= mat.load_data;
    end

endmodule

`default_nettype wire

// File: src/gl_decode.sv
`timescale 1ns/100ps
`default_nettype none

module gl_decode
    import gl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_req,
    input  gl_word_u         cmd_word,
    output logic             cmd_ack,
    gl_mat_if.ctrl           mat,
    output logic             mul_start,
    output logic [VEC_W-1:0] mul_vec,
    input  logic             mul_done,
    input  logic [VEC_W-1:0] mul_result,
    output logic             fifo_push,
    output logic [OUT_W-1:0] fifo_data,
    input  logic             fifo_full
);
    logic [ST_W-1:0]   state;
    logic [7:0]        opcode_q;
    logic [3:0]        cnt;         // Operand index
    logic [1:0]        sub;         // Row being written back
    logic [1:0]        col;
    logic              mode_q;      // Mode set by MATRIXMODE
    logic [WORD_W-1:0] red;
    logic [WORD_W-1:0] green;
    logic [WORD_W-1:0] blue;
    logic [VEC_W-1:0]  vbuf;        // Vertex or operand column
    logic              take;

    // Words are only taken while no sequence runs
    assign take = cmd_req && !cmd_ack && (state == ST_CMD || state == ST_OPND);

    assign mul_vec   = (state == ST_MUL2) ? mul_result : vbuf;
    assign fifo_push = (state == ST_PUSH) && !fifo_full;
    assign fifo_data = {blue, green, red, mul_result};

    //////////////////////////////
    // Input handshake
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cmd_ack <= 1'b0;
        else if (take)
            cmd_ack <= 1'b1;
        else if (!cmd_req)
            cmd_ack <= 1'b0;
    end

    //////////////////////////////
    // Sequencer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= ST_CMD;
            opcode_q     <= '0;
            cnt          <= '0;
            sub          <= '0;
            mode_q       <= MODE_MODELVIEW;
            mat.mode     <= MODE_MODELVIEW;
            mat.load_en  <= 1'b0;
            mat.commit   <= 1'b0;
            mat.identity <= 1'b0;
            mat.push     <= 1'b0;
            mat.pop      <= 1'b0;
            mul_start    <= 1'b0;
            red          <= '0;
            green        <= '0;
            blue         <= '0;
        end
        else
        begin
            mat.load_en  <= 1'b0;
            mat.identity <= 1'b0;
            mat.push     <= 1'b0;
            mat.pop      <= 1'b0;
            mul_start    <= 1'b0;
            mat.commit   <= mat.load_en && mat.load_idx == 4'd15;   // Last element just written

            case (state)
                ST_CMD:
                    if (take)
                    begin
                        opcode_q <= cmd_word.cmd.opcode;
                        cnt      <= '0;
                        case (cmd_word.cmd.opcode)
                            OP_VERTEX, OP_COLOR, OP_LOADMATRIX, OP_MULTMATRIX:
                                state <= ST_OPND;
                            OP_MATRIXMODE:
                            begin
                                mode_q   <= cmd_word.cmd.imm[0];
                                mat.mode <= cmd_word.cmd.imm[0];
                            end
                            OP_LOADID:     mat.identity <= 1'b1;
                            OP_PUSHMATRIX: mat.push     <= 1'b1;
                            OP_POPMATRIX:  mat.pop      <= 1'b1;
                            OP_BEGIN, OP_END: ;     // No effect
                            default: ;
                        endcase
                    end

                ST_OPND:
                    if (take)
                    begin
                        cnt <= cnt + 1'b1;
                        case (opcode_q)
                            OP_COLOR:
                            begin
                                case (cnt[1:0])
                                    2'd0:    red   <= cmd_word.data;
                                    2'd1:    green <= cmd_word.data;
                                    default: blue  <= cmd_word.data;
                                endcase
                                if (cnt == 4'd2)
                                    state <= ST_CMD;
                            end
                            OP_LOADMATRIX:
                            begin
                                mat.load_en <= 1'b1;
                                if (cnt == 4'd15)
                                    state <= ST_CMD;
                            end
                            OP_VERTEX:
                                if (cnt == 4'd2)
                                begin
                                    mat.mode  <= MODE_MODELVIEW;
                                    mul_start <= 1'b1;
                                    state     <= ST_MUL1;
                                end
                            default:                // MULTMATRIX, one column per pass
                                if (cnt[1:0] == 2'd3)
                                begin
                                    mul_start <= 1'b1;
                                    state     <= ST_MUL1;
                                end
                        endcase
                    end

                ST_MUL1:
                    if (mul_done)
                    begin
                        if (opcode_q == OP_VERTEX)
                        begin
                            mat.mode  <= MODE_PROJECTION;
                            mul_start <= 1'b1;
                            state     <= ST_MUL2;
                        end
                        else
                        begin
                            sub   <= '0;
                            state <= ST_STORE;
                        end
                    end

                ST_MUL2:
                    if (mul_done)
                    begin
                        mat.mode <= mode_q;
                        state    <= ST_PUSH;
                    end

                ST_PUSH:
                    if (!fifo_full)
                        state <= ST_CMD;

                ST_STORE:
                begin
                    mat.load_en <= 1'b1;
                    sub         <= sub + 1'b1;
                    if (sub == 2'd3)
                        state <= (col == 2'd3) ? ST_CMD : ST_OPND;
                end

                default: state <= ST_CMD;
            endcase
        end
    end

    // Operand and staging data path
    always_ff @(posedge clk)
    begin
        if (take && state == ST_OPND)
        begin
            vbuf[cnt[1:0]*WORD_W +: WORD_W] <= cmd_word.data;
            if (opcode_q == OP_VERTEX)
                vbuf[3*WORD_W +: WORD_W] <= ONE_Q;      // Implicit w
            mat.load_idx  <= cnt;
            mat.load_data <= cmd_word.data;
            col           <= cnt[3:2];
        end
        if (state == ST_STORE)
        begin
            mat.load_idx  <= {col, sub};
            mat.load_data <= mul_result[sub*WORD_W +: WORD_W];
        end
    end

endmodule

`default_nettype wire

// File: src/gl_mat_if.sv
`timescale 1ns/100ps
`default_nettype none

interface gl_mat_if
    import gl_pkg::*;
();
    logic              mode;        // Matrix set addressed
    logic              load_en;
    logic [3:0]        load_idx;    // col*4+row
    logic [WORD_W-1:0] load_data;
    logic              commit;      // Staging into current
    logic              identity;
    logic              push;
    logic              pop;
    logic [MAT_W-1:0]  mat;         // Current matrix of mode

    modport ctrl (
        output mode, load_en, load_idx, load_data, commit, identity, push, pop,
        input  mat
    );

    modport store (
        input  mode, load_en, load_idx, load_data, commit, identity, push, pop,
        output mat
    );

endinterface

`default_nettype wire

// File: src/gl_pkg.sv
`default_nettype none

package gl_pkg;

    //////////////////////////////
    // Widths and Q16.16 constants
    localparam int WORD_W = 32;
    localparam int FRAC_W = 16;
    localparam int MAT_W  = 16 * WORD_W;   // Column-major, element col*4+row
    localparam int VEC_W  = 4 * WORD_W;
    localparam int OUT_W  = 7 * WORD_W;    // x y z w r g b, x in the low word

    localparam logic [WORD_W-1:0] ONE_Q = 32'h0001_0000;

    localparam int STACK_DEPTH = 4;
    localparam int SP_W        = $clog2(STACK_DEPTH) + 1;
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

    //////////////////////////////
    // Opcodes
    localparam logic [7:0] OP_BEGIN      = 8'h01;
    localparam logic [7:0] OP_END        = 8'h02;
    localparam logic [7:0] OP_VERTEX     = 8'h03;
    localparam logic [7:0] OP_COLOR      = 8'h04;
    localparam logic [7:0] OP_MATRIXMODE = 8'h10;
    localparam logic [7:0] OP_MULTMATRIX = 8'h11;
    localparam logic [7:0] OP_LOADID     = 8'h12;
    localparam logic [7:0] OP_LOADMATRIX = 8'h13;
    localparam logic [7:0] OP_PUSHMATRIX = 8'h14;
    localparam logic [7:0] OP_POPMATRIX  = 8'h15;

    localparam logic MODE_MODELVIEW  = 1'b0;
    localparam logic MODE_PROJECTION = 1'b1;

    // Decoder states
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_CMD   = 3'd0;   // Expecting a command word
    localparam logic [ST_W-1:0] ST_OPND  = 3'd1;   // Expecting operands
    localparam logic [ST_W-1:0] ST_MUL1  = 3'd2;
    localparam logic [ST_W-1:0] ST_MUL2  = 3'd3;   // Projection pass of a vertex
    localparam logic [ST_W-1:0] ST_PUSH  = 3'd4;
    localparam logic [ST_W-1:0] ST_STORE = 3'd5;   // Column write-back to staging

    // One input word, read as a command or as a datum
    typedef union packed {
        struct packed {
            logic [7:0]  opcode;
            logic [23:0] imm;      // Bit 0 carries the matrix mode
        } cmd;
        logic signed [WORD_W-1:0] data;
    } gl_word_u;

endpackage

`default_nettype wire
